// File: bench/ntt_bf_chk.sv
// Concurrent assertions on one butterfly lane, bound to every ntt_masked_gs_bf instance
`include "ntt_settings.svh"

module ntt_bf_chk (
    input logic            clk,
    input logic            reset_n,
    input logic            zeroize_i,
    input logic            valid_i,
    input logic            out_valid_i,
    input ntt_pkg::coeff_t up0_i,
    input ntt_pkg::coeff_t up1_i,
    input ntt_pkg::coeff_t vp0_i,
    input ntt_pkg::coeff_t vp1_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LAT = `NTT_BF_LATENCY;
    localparam int Q   = `NTT_Q;

    // Zeroize seen in any of the last LAT cycles
    logic [LAT-1:0] zero_hist;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            zero_hist <= '0;
        end else begin
            zero_hist <= {zero_hist[LAT-2:0], zeroize_i};
        end
    end

    valid_latency: assert property (@(posedge clk) disable iff (!reset_n)
        (zero_hist == '0) |-> (out_valid_i == $past(valid_i, LAT)))
        else $error("lane valid_o does not follow valid_i by the lane latency");

    shares_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid_i |-> (up0_i < Q && up1_i < Q && vp0_i < Q && vp1_i < Q))
        else $error("lane output share is not below the modulus");

    zeroize_clears: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !out_valid_i)
        else $error("lane valid_o high in the cycle after zeroize");

endmodule

bind ntt_masked_gs_bf ntt_bf_chk i_ntt_bf_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .zeroize_i   (zeroize_i),
    .valid_i     (valid_i),
    .out_valid_i (valid_o),
    .up0_i       (up0_o),
    .up1_i       (up1_o),
    .vp0_i       (vp0_o),
    .vp1_i       (vp1_o)
);

// File: bench/ntt_clk_gen.sv
// Testbench clock and power-on reset source, instantiated once by the testbench top
module ntt_clk_gen (
    output logic clk_o,
    output logic reset_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD_NS clk_o = ~clk_o;
    end

    // Release away from the active edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule

// File: bench/ntt_tb.sv
// Table-driven testbench for the masked inverse-NTT engine and top module of the simulation
`include "ntt_settings.svh"

module ntt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NB         = `NTT_NUM_BF;
    localparam int          Q          = `NTT_Q;
    localparam int          NUM_FIXED  = 3;
    localparam int          NUM_ROWS   = 8;
    localparam int          LAST       = NUM_ROWS - 1;
    localparam int          ADR_CTRL   = 0;
    localparam int          ADR_STATUS = 1;
    localparam int          ADR_OP     = 16;
    localparam int          ADR_RES    = 32;
    localparam int          ACK_LIMIT  = 16;
    localparam int          POLL_LIMIT = 64;
    localparam int unsigned SEED       = 32'heb87_f31b;

    logic             clk;
    logic             reset_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic             wb_ack;
    ntt_pkg::wb_adr_t wb_adr;
    ntt_pkg::wb_dat_t wb_dat_w;
    ntt_pkg::wb_dat_t wb_dat_r;

    // Operands and expected results for each run
    int tbl_u  [NUM_ROWS][NB];
    int tbl_v  [NUM_ROWS][NB];
    int tbl_w  [NUM_ROWS][NB];
    int tbl_up [NUM_ROWS][NB];
    int tbl_vp [NUM_ROWS][NB];

    ntt_clk_gen i_ntt_clk_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    ntt_bf_array_top i_ntt_bf_array_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_r)
    );

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp_val, act_val);
            abort_run("value mismatch");
        end
    endtask

    // One classic cycle with stb held through the edge where ack is high
    task automatic bus_xfer(input logic we, input int adr, input int wdat, output int rdat);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = ntt_pkg::wb_adr_t'(adr);
        wb_dat_w = ntt_pkg::wb_dat_t'(wdat);
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            abort_run($sformatf("no Wishbone ack for address %0d", adr));
        end
        rdat = int'(wb_dat_r);
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input int adr, input int dat);
        int unused;
        bus_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic expect_read(input string name, input int adr, input int exp_val);
        int act;
        bus_xfer(1'b0, adr, 0, act);
        check_val(name, exp_val, act);
    endtask

    // Reference butterfly from the GS rules
    function automatic void set_lane(int r, int l, int u, int v, int w);
        tbl_u[r][l]  = u;
        tbl_v[r][l]  = v;
        tbl_w[r][l]  = w;
        tbl_up[r][l] = (u + v) % Q;
        tbl_vp[r][l] = (((u - v + Q) % Q) * w) % Q;
    endfunction

    task automatic fill_table();
        set_lane(0, 0, 0, 0, 0);
        set_lane(0, 1, 1, 1, 1);
        set_lane(0, 2, Q - 1, Q - 1, Q - 1);
        set_lane(0, 3, 0, 1, Q - 1);
        set_lane(1, 0, 1, 0, Q - 1);
        set_lane(1, 1, Q - 1, 0, 1);
        set_lane(1, 2, 0, Q - 1, 1);
        set_lane(1, 3, 1234, 1234, 77);
        set_lane(2, 0, Q - 1, 1, Q - 1);
        set_lane(2, 1, 1, Q - 1, 2);
        set_lane(2, 2, 2, 3, Q - 1);
        set_lane(2, 3, 17, 100, 1);
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            for (int l = 0; l < NB; l++) begin
                set_lane(r, l, int'($urandom % Q), int'($urandom % Q), int'($urandom % Q));
            end
        end
    endtask

    task automatic load_row(input int r);
        for (int l = 0; l < NB; l++) begin
            wb_write(ADR_OP + 4 * l, tbl_u[r][l]);
            wb_write(ADR_OP + 4 * l + 1, tbl_v[r][l]);
            wb_write(ADR_OP + 4 * l + 2, tbl_w[r][l]);
        end
    endtask

    // Poll until done is set and busy is clear
    // Stale done of the last run reads together with busy
    task automatic wait_done(input string tag);
        int st;
        int polls;
        st    = 0;
        polls = 0;
        while (st != 2) begin
            if (polls == POLL_LIMIT) begin
                abort_run({tag, ": engine did not report done within 64 STATUS reads"});
            end
            bus_xfer(1'b0, ADR_STATUS, 0, st);
            polls++;
        end
    endtask

    task automatic check_results(input int r, input string tag);
        for (int l = 0; l < NB; l++) begin
            expect_read($sformatf("%s lane %0d u'", tag, l), ADR_RES + 2 * l, tbl_up[r][l]);
            expect_read($sformatf("%s lane %0d v'", tag, l), ADR_RES + 2 * l + 1, tbl_vp[r][l]);
        end
    endtask

    task automatic expect_cleared(input string tag);
        expect_read({tag, " status"}, ADR_STATUS, 0);
        for (int a = ADR_RES; a < ADR_RES + 2 * NB; a++) begin
            expect_read($sformatf("%s result addr %0d", tag, a), a, 0);
        end
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(SEED));
        fill_table();
        wait (reset_n === 1'b1);

        expect_cleared("after reset");

        // Only the low 12 bits of an operand are stored
        wb_write(ADR_OP, 32'hffff_f123);
        expect_read("operand width", ADR_OP, 12'h123);
        load_row(0);
        for (int l = 0; l < NB; l++) begin
            expect_read($sformatf("readback lane %0d u", l), ADR_OP + 4 * l, tbl_u[0][l]);
            expect_read($sformatf("readback lane %0d v", l), ADR_OP + 4 * l + 1, tbl_v[0][l]);
            expect_read($sformatf("readback lane %0d w", l), ADR_OP + 4 * l + 2, tbl_w[0][l]);
        end
        wb_write(2, 32'h5a5);
        wb_write(ADR_OP + 3, 32'h777);
        wb_write(48, 32'h123);
        wb_write(63, 32'hffff_ffff);
        expect_read("unmapped 2", 2, 0);
        expect_read("unmapped 19", ADR_OP + 3, 0);
        expect_read("unmapped 48", 48, 0);
        expect_read("unmapped 63", 63, 0);
        expect_read("lane 0 u after unmapped writes", ADR_OP, tbl_u[0][0]);
        expect_read("status after unmapped writes", ADR_STATUS, 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            load_row(r);
            wb_write(ADR_CTRL, 1);
            wait_done($sformatf("row %0d", r));
            check_results(r, $sformatf("row %0d", r));
        end

        // Lane 0 is already launched when its new u lands
        // An accepted second start would relaunch it with the new value
        load_row(LAST);
        wb_write(ADR_CTRL, 1);
        wb_write(ADR_OP, (tbl_u[LAST][0] + 1) % Q);
        wb_write(ADR_CTRL, 1);
        expect_read("busy during run", ADR_STATUS, 1);
        wait_done("restart");
        check_results(LAST, "restart");
        wb_write(ADR_OP, tbl_u[LAST][0]);

        // Zeroize keeps the operands
        wb_write(ADR_CTRL, 2);
        expect_cleared("after zeroize");
        wb_write(ADR_CTRL, 1);
        wait_done("rerun");
        check_results(LAST, "rerun");

        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat ((NUM_ROWS + 4) * 200) @(posedge clk);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module ntt_tb -f vlog.f -o ntt_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ntt_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: src/ntt_bf_array_top.sv
// Top level of the masked inverse-NTT engine that wires the register block, feeder, lanes and collector
`include "ntt_settings.svh"

module ntt_bf_array_top (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  ntt_pkg::wb_adr_t wb_adr_i,
    input  ntt_pkg::wb_dat_t wb_dat_i,
    output logic             wb_ack_o,
    output ntt_pkg::wb_dat_t wb_dat_o
);

    localparam int NB = `NTT_NUM_BF;
    localparam int CW = `NTT_COEFF_W;

    logic             start;
    logic             zeroize;
    logic             done;
    logic [NB*CW-1:0] op_u;
    logic [NB*CW-1:0] op_v;
    logic [NB*CW-1:0] op_w;
    logic [NB*CW-1:0] res_u;
    logic [NB*CW-1:0] res_v;
    logic [NB-1:0]    lane_valid;
    logic [NB-1:0]    bf_valid;
    ntt_pkg::coeff_t  u0;
    ntt_pkg::coeff_t  u1;
    ntt_pkg::coeff_t  v0;
    ntt_pkg::coeff_t  v1;
    ntt_pkg::coeff_t  w0;
    ntt_pkg::coeff_t  w1;
    ntt_pkg::coeff_t  rnd;
    logic [NB*CW-1:0] up0;
    logic [NB*CW-1:0] up1;
    logic [NB*CW-1:0] vp0;
    logic [NB*CW-1:0] vp1;

    ntt_wb_regs i_ntt_wb_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .done_i    (done),
        .res_u_i   (res_u),
        .res_v_i   (res_v),
        .start_o   (start),
        .zeroize_o (zeroize),
        .op_u_o    (op_u),
        .op_v_o    (op_v),
        .op_w_o    (op_w)
    );

    ntt_share_split i_ntt_share_split (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start),
        .zeroize_i    (zeroize),
        .op_u_i       (op_u),
        .op_v_i       (op_v),
        .op_w_i       (op_w),
        .lane_valid_o (lane_valid),
        .u0_o         (u0),
        .u1_o         (u1),
        .v0_o         (v0),
        .v1_o         (v1),
        .w0_o         (w0),
        .w1_o         (w1),
        .rnd_o        (rnd)
    );

    // Each lane picks up its own launch bit from the common share buses
    for (genvar i = 0; i < NB; i++) begin : g_lane
        ntt_masked_gs_bf i_ntt_masked_gs_bf (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize),
            .valid_i   (lane_valid[i]),
            .u0_i      (u0),
            .u1_i      (u1),
            .v0_i      (v0),
            .v1_i      (v1),
            .w0_i      (w0),
            .w1_i      (w1),
            .rnd_i     (rnd),
            .valid_o   (bf_valid[i]),
            .up0_o     (up0[i*CW +: CW]),
            .up1_o     (up1[i*CW +: CW]),
            .vp0_o     (vp0[i*CW +: CW]),
            .vp1_o     (vp1[i*CW +: CW])
        );
    end

    ntt_unmask_collect i_ntt_unmask_collect (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (start),
        .zeroize_i (zeroize),
        .valid_i   (bf_valid),
        .up0_i     (up0),
        .up1_i     (up1),
        .vp0_i     (vp0),
        .vp1_i     (vp1),
        .done_o    (done),
        .res_u_o   (res_u),
        .res_v_o   (res_v)
    );

endmodule

// File: src/ntt_masked_gs_bf.sv
// One masked Gentleman-Sande butterfly lane on two-share operands, three stages deep
module ntt_masked_gs_bf (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  logic            valid_i,
    input  ntt_pkg::coeff_t u0_i,
    input  ntt_pkg::coeff_t u1_i,
    input  ntt_pkg::coeff_t v0_i,
    input  ntt_pkg::coeff_t v1_i,
    input  ntt_pkg::coeff_t w0_i,
    input  ntt_pkg::coeff_t w1_i,
    input  ntt_pkg::coeff_t rnd_i,
    output logic            valid_o,
    output ntt_pkg::coeff_t up0_o,
    output ntt_pkg::coeff_t up1_o,
    output ntt_pkg::coeff_t vp0_o,
    output ntt_pkg::coeff_t vp1_o
);

    logic            s1_valid;
    logic            s2_valid;

    // Stage 1: share-wise sum and difference
    ntt_pkg::coeff_t s1_a0;
    ntt_pkg::coeff_t s1_a1;
    ntt_pkg::coeff_t s1_d0;
    ntt_pkg::coeff_t s1_d1;
    ntt_pkg::coeff_t s1_w0;
    ntt_pkg::coeff_t s1_w1;
    ntt_pkg::coeff_t s1_rnd;

    // Stage 2: cross products, refresh already folded in
    ntt_pkg::coeff_t s2_a0;
    ntt_pkg::coeff_t s2_a1;
    ntt_pkg::coeff_t s2_p00;
    ntt_pkg::coeff_t s2_p01;
    ntt_pkg::coeff_t s2_p10;
    ntt_pkg::coeff_t s2_p11;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else if (zeroize_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            s2_valid <= s1_valid;
            valid_o  <= s2_valid;
        end
    end

    // Share data is wiped by zeroize so no secret lingers in the pipe
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            s1_a0  <= '0;
            s1_a1  <= '0;
            s1_d0  <= '0;
            s1_d1  <= '0;
            s1_w0  <= '0;
            s1_w1  <= '0;
            s1_rnd <= '0;
            s2_a0  <= '0;
            s2_a1  <= '0;
            s2_p00 <= '0;
            s2_p01 <= '0;
            s2_p10 <= '0;
            s2_p11 <= '0;
            up0_o  <= '0;
            up1_o  <= '0;
            vp0_o  <= '0;
            vp1_o  <= '0;
        end else begin
            s1_a0  <= ntt_pkg::mod_add(u0_i, v0_i);
            s1_a1  <= ntt_pkg::mod_add(u1_i, v1_i);
            s1_d0  <= ntt_pkg::mod_sub(u0_i, v0_i);
            s1_d1  <= ntt_pkg::mod_sub(u1_i, v1_i);
            s1_w0  <= w0_i;
            s1_w1  <= w1_i;
            s1_rnd <= rnd_i;

            // (d0 + d1)(w0 + w1), refresh cancels across the two output shares
            s2_a0  <= s1_a0;
            s2_a1  <= s1_a1;
            s2_p00 <= ntt_pkg::mod_add(ntt_pkg::mod_mul(s1_d0, s1_w0), s1_rnd);
            s2_p01 <= ntt_pkg::mod_mul(s1_d0, s1_w1);
            s2_p10 <= ntt_pkg::mod_mul(s1_d1, s1_w0);
            s2_p11 <= ntt_pkg::mod_sub(ntt_pkg::mod_mul(s1_d1, s1_w1), s1_rnd);

            up0_o  <= s2_a0;
            up1_o  <= s2_a1;
            vp0_o  <= ntt_pkg::mod_add(s2_p00, s2_p01);
            vp1_o  <= ntt_pkg::mod_add(s2_p11, s2_p10);
        end
    end

endmodule

// File: src/ntt_pkg.sv
// Shared types and modulo-q arithmetic for the engine, referenced with scoped names
`include "ntt_settings.svh"

package ntt_pkg;

    typedef logic [`NTT_COEFF_W-1:0]         coeff_t;
    typedef logic [2*`NTT_COEFF_W-1:0]       prod_t;
    typedef logic [$clog2(`NTT_NUM_BF)-1:0]  lane_idx_t;
    typedef logic [`NTT_WB_ADR_W-1:0]        wb_adr_t;
    typedef logic [`NTT_WB_DAT_W-1:0]        wb_dat_t;

    // Feeder FSM
    typedef enum logic {
        IDLE,
        SPLIT
    } split_state_t;

    localparam coeff_t Q = coeff_t'(`NTT_Q);

    // Operands below q, one conditional subtract
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, Q}) begin
            sum = sum - {1'b0, Q};
        end
        return sum[`NTT_COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        coeff_t diff;
        if (a >= b) begin
            diff = a - b;
        end else begin
            // Wraps back into range
            diff = a + (Q - b);
        end
        return diff;
    endfunction

    function automatic coeff_t mod_mul(coeff_t a, coeff_t b);
        prod_t p;
        prod_t r;
        p = prod_t'(a) * prod_t'(b);
        r = p % prod_t'(Q);
        return r[`NTT_COEFF_W-1:0];
    endfunction

endpackage

// File: src/ntt_settings.svh
// Global sizes of the masked inverse-NTT engine, included by every file that needs them
`ifndef NTT_SETTINGS_SVH
`define NTT_SETTINGS_SVH

// ML-KEM modulus
`define NTT_Q 3329

// Coefficient and share width
`define NTT_COEFF_W 12

// Butterfly lanes, also sets the operand and result address ranges
`define NTT_NUM_BF 4

// Cycles from lane valid_i to valid_o
`define NTT_BF_LATENCY 3

// Wishbone word address and data widths
`define NTT_WB_ADR_W 6
`define NTT_WB_DAT_W 32

`endif

// File: src/ntt_share_split.sv
// Feeder that launches one lane per cycle with freshly masked operand shares
`include "ntt_settings.svh"

module ntt_share_split (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                start_i,
    input  logic                                zeroize_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_u_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_v_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_w_i,
    output logic [`NTT_NUM_BF-1:0]              lane_valid_o,
    output ntt_pkg::coeff_t                     u0_o,
    output ntt_pkg::coeff_t                     u1_o,
    output ntt_pkg::coeff_t                     v0_o,
    output ntt_pkg::coeff_t                     v1_o,
    output ntt_pkg::coeff_t                     w0_o,
    output ntt_pkg::coeff_t                     w1_o,
    output ntt_pkg::coeff_t                     rnd_o
);

    localparam int          CW        = `NTT_COEFF_W;
    localparam logic [63:0] PRNG_SEED = 64'h9e37_79b9_7f4a_7c15;

    ntt_pkg::split_state_t state;
    ntt_pkg::lane_idx_t    lane_idx;
    logic [63:0]           prng;
    logic [63:0]           prng_next;
    ntt_pkg::coeff_t       r_u;
    ntt_pkg::coeff_t       r_v;
    ntt_pkg::coeff_t       r_w;

    // Fold a raw draw into [0, q)
    function automatic ntt_pkg::coeff_t fold_q(ntt_pkg::coeff_t d);
        return (d >= ntt_pkg::Q) ? d - ntt_pkg::Q : d;
    endfunction

    // xorshift64
    always_comb begin
        prng_next = prng ^ (prng << 13);
        prng_next = prng_next ^ (prng_next >> 7);
        prng_next = prng_next ^ (prng_next << 17);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ntt_pkg::IDLE;
            lane_idx <= '0;
            prng     <= PRNG_SEED;
        end else begin
            prng <= prng_next;
            if (zeroize_i) begin
                state    <= ntt_pkg::IDLE;
                lane_idx <= '0;
            end else begin
                case (state)
                    ntt_pkg::IDLE: begin
                        if (start_i) begin
                            state    <= ntt_pkg::SPLIT;
                            lane_idx <= '0;
                        end
                    end
                    ntt_pkg::SPLIT: begin
                        if (lane_idx == ntt_pkg::lane_idx_t'(`NTT_NUM_BF - 1)) begin
                            state <= ntt_pkg::IDLE;
                        end else begin
                            lane_idx <= lane_idx + 1'b1;
                        end
                    end
                    default: state <= ntt_pkg::IDLE;
                endcase
            end
        end
    end

    // Four draws per cycle: three masks and the refresh term
    assign r_u   = fold_q(prng[CW-1:0]);
    assign r_v   = fold_q(prng[16 +: CW]);
    assign r_w   = fold_q(prng[32 +: CW]);
    assign rnd_o = fold_q(prng[48 +: CW]);

    assign u0_o = r_u;
    assign v0_o = r_v;
    assign w0_o = r_w;
    assign u1_o = ntt_pkg::mod_sub(op_u_i[lane_idx*CW +: CW], r_u);
    assign v1_o = ntt_pkg::mod_sub(op_v_i[lane_idx*CW +: CW], r_v);
    assign w1_o = ntt_pkg::mod_sub(op_w_i[lane_idx*CW +: CW], r_w);

    always_comb begin
        lane_valid_o = '0;
        if (state == ntt_pkg::SPLIT) begin
            lane_valid_o[lane_idx] = 1'b1;
        end
    end

endmodule

// File: src/ntt_unmask_collect.sv
// Drain that recombines lane output shares, holds results and flags completion
`include "ntt_settings.svh"

module ntt_unmask_collect (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                start_i,
    input  logic                                zeroize_i,
    input  logic [`NTT_NUM_BF-1:0]              valid_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] up0_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] up1_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] vp0_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] vp1_i,
    output logic                                done_o,
    output logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] res_u_o,
    output logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] res_v_o
);

    localparam int NB = `NTT_NUM_BF;
    localparam int CW = `NTT_COEFF_W;

    // One mark per lane that has reported this run
    logic [NB-1:0] recv;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            recv    <= '0;
            done_o  <= 1'b0;
            res_u_o <= '0;
            res_v_o <= '0;
        end else if (zeroize_i) begin
            recv    <= '0;
            done_o  <= 1'b0;
            res_u_o <= '0;
            res_v_o <= '0;
        end else begin
            if (start_i) begin
                recv   <= '0;
                done_o <= 1'b0;
            end else begin
                done_o <= &recv;
            end
            for (int i = 0; i < NB; i++) begin
                if (valid_i[i]) begin
                    res_u_o[i*CW +: CW] <= ntt_pkg::mod_add(up0_i[i*CW +: CW],
                                                            up1_i[i*CW +: CW]);
                    res_v_o[i*CW +: CW] <= ntt_pkg::mod_add(vp0_i[i*CW +: CW],
                                                            vp1_i[i*CW +: CW]);
                    recv[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: src/ntt_wb_regs.sv
// Wishbone classic slave holding operands, run control, status and result readback
`include "ntt_settings.svh"

module ntt_wb_regs (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  ntt_pkg::wb_adr_t                    wb_adr_i,
    input  ntt_pkg::wb_dat_t                    wb_dat_i,
    output logic                                wb_ack_o,
    output ntt_pkg::wb_dat_t                    wb_dat_o,
    input  logic                                done_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] res_u_i,
    input  logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] res_v_i,
    output logic                                start_o,
    output logic                                zeroize_o,
    output logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_u_o,
    output logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_v_o,
    output logic [`NTT_NUM_BF*`NTT_COEFF_W-1:0] op_w_o
);

    localparam int NB = `NTT_NUM_BF;
    localparam int CW = `NTT_COEFF_W;

    // Word address map
    localparam int ADR_CTRL     = 0;
    localparam int ADR_STATUS   = 1;
    localparam int ADR_OP_BASE  = 16;
    localparam int ADR_RES_BASE = 32;

    logic             req;
    logic             wr_cyc;
    logic             ctrl_wr;
    logic             start_set;
    logic             busy;
    ntt_pkg::wb_dat_t rd_data;

    // New request, not yet acknowledged
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // Writes take effect in the ack cycle
    assign wr_cyc  = wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o;
    assign ctrl_wr = wr_cyc && (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_CTRL));

    // Zeroize bit wins over start, and start is dropped while busy
    assign start_set = ctrl_wr && wb_dat_i[0] && !wb_dat_i[1] && !busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack_o  <= 1'b0;
            wb_dat_o  <= '0;
            start_o   <= 1'b0;
            zeroize_o <= 1'b0;
            busy      <= 1'b0;
        end else begin
            wb_ack_o  <= req;
            wb_dat_o  <= req ? rd_data : '0;
            start_o   <= start_set;
            zeroize_o <= ctrl_wr && wb_dat_i[1];
            if (zeroize_o) begin
                busy <= 1'b0;
            end else if (start_set) begin
                busy <= 1'b1;
            // Done of the previous run is still high during the start pulse
            end else if (done_i && !start_o) begin
                busy <= 1'b0;
            end
        end
    end

    // Operand registers survive zeroize
    always_ff @(posedge clk) begin
        for (int i = 0; i < NB; i++) begin
            if (wr_cyc && wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i)) begin
                op_u_o[i*CW +: CW] <= wb_dat_i[CW-1:0];
            end
            if (wr_cyc && wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i + 1)) begin
                op_v_o[i*CW +: CW] <= wb_dat_i[CW-1:0];
            end
            if (wr_cyc && wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i + 2)) begin
                op_w_o[i*CW +: CW] <= wb_dat_i[CW-1:0];
            end
        end
    end

    // Read mux, unmapped addresses stay 0
    always_comb begin
        rd_data = '0;
        if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_STATUS)) begin
            rd_data = ntt_pkg::wb_dat_t'({done_i, busy});
        end
        for (int i = 0; i < NB; i++) begin
            if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i)) begin
                rd_data = ntt_pkg::wb_dat_t'(op_u_o[i*CW +: CW]);
            end
            if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i + 1)) begin
                rd_data = ntt_pkg::wb_dat_t'(op_v_o[i*CW +: CW]);
            end
            if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_OP_BASE + 4 * i + 2)) begin
                rd_data = ntt_pkg::wb_dat_t'(op_w_o[i*CW +: CW]);
            end
            if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_RES_BASE + 2 * i)) begin
                rd_data = ntt_pkg::wb_dat_t'(res_u_i[i*CW +: CW]);
            end
            if (wb_adr_i == ntt_pkg::wb_adr_t'(ADR_RES_BASE + 2 * i + 1)) begin
                rd_data = ntt_pkg::wb_dat_t'(res_v_i[i*CW +: CW]);
            end
        end
    end

endmodule

// File: vlog.f
+incdir+src
src/ntt_pkg.sv
src/ntt_wb_regs.sv
src/ntt_share_split.sv
src/ntt_masked_gs_bf.sv
src/ntt_unmask_collect.sv
src/ntt_bf_array_top.sv
bench/ntt_clk_gen.sv
bench/ntt_bf_chk.sv
bench/ntt_tb.sv
